// File: project.f
verilog/bridge_pkg.sv
verilog/axi_read_channel.sv
verilog/axi_write_channel.sv
verilog/refill_arbiter.sv
verilog/cache_axi_bridge.sv
testbench/tb_clock_gen.sv
testbench/bridge_properties.sv
testbench/tb_cache_axi_bridge.sv

// File: testbench/bridge_golden.txt
# Cache refill bridge transactions, one per line, all fields hex
# op addr wdata type expect : expect is ARLEN for I D DU ID, WSTRB for W
# ID raises I and D together, the data address sits in the wdata column
I  00000100 00000000 0 3
I  00400020 00000000 0 3
D  20000040 00000000 0 3
DU 10000008 00000000 0 0
D  1001fff0 00000000 0 3
DU 1000fffc 00000000 0 0
W  20000100 cafef00d 0 f
W  20000104 12345678 c 3
W  10000010 a5a5a5a5 e 1
ID 00000200 20000080 0 3
ID 00000300 10000004 0 0
D  0fff0000 00000000 0 3
I  80000000 00000000 0 3
W  30000008 0badbeef 5 a
DU 10001230 00000000 0 0
ID 00000400 30000100 0 3
W  1000fff8 76543210 3 c
I  00000ff0 00000000 0 3
D  fffffff0 00000000 0 3
W  20000200 deadc0de f 0

// File: testbench/bridge_properties.sv
`timescale 1ns/1ps

module bridge_properties
    import bridge_pkg::*;
(
    input logic    ACLK,
    input logic    ARESETn,
    input axi_ar_t m0_ar_i,
    input logic    m0_arready_i,
    input logic    m0_rready_i,
    input axi_ar_t m1_ar_i,
    input logic    m1_arready_i,
    input logic    m1_rready_i
);

    ////////////////////
    // AR stability
    ////////////////////
    // Stalled request must not move
    m0_ar_stable: assert property (@(posedge ACLK) disable iff (!ARESETn)
        (m0_ar_i.valid && !m0_arready_i) |=> $stable(m0_ar_i))
        else $error("M0 AR changed while ARREADY low");

    m1_ar_stable: assert property (@(posedge ACLK) disable iff (!ARESETn)
        (m1_ar_i.valid && !m1_arready_i) |=> $stable(m1_ar_i))
        else $error("M1 AR changed while ARREADY low");

    // Single read FSM lets one port receive at a time
    rready_exclusive: assert property (@(posedge ACLK) disable iff (!ARESETn)
        !(m0_rready_i && m1_rready_i))
        else $error("RREADY high on both ports");

    // Reset clears both AR channels
    ar_reset: assert property (@(posedge ACLK)
        !ARESETn |=> (!m0_ar_i.valid && !m1_ar_i.valid))
        else $error("ARVALID high after reset");

endmodule : bridge_properties

bind cache_axi_bridge bridge_properties props (
    .ACLK         (ACLK),
    .ARESETn      (ARESETn),
    .m0_ar_i      (m0_ar_o),
    .m0_arready_i (m0_arready_i),
    .m0_rready_i  (m0_rready_o),
    .m1_ar_i      (m1_ar_o),
    .m1_arready_i (m1_arready_i),
    .m1_rready_i  (m1_rready_o)
);

// File: testbench/tb_cache_axi_bridge.sv
`timescale 1ns/1ps

module tb_cache_axi_bridge
    import bridge_pkg::*;
();

    localparam int CLK_PERIOD    = 20;
    localparam int CYCLES_PER_TX = 200;

    logic    ACLK;
    logic    ARESETn;
    logic    i_req;
    addr_t   i_addr;
    logic    i_wait;
    logic    d_req;
    logic    d_write;
    addr_t   d_addr;
    data_t   d_wdata;
    strb_t   d_type;
    logic    d_wait;
    axi_ar_t m0_ar;
    axi_ar_t m1_ar;
    logic    m0_rready;
    logic    m1_rready;
    axi_aw_t m1_aw;
    axi_w_t  m1_w;
    logic    m1_awready;
    logic    m1_wready;
    axi_b_t  m1_b;
    logic    m1_bready;

    // Slave side indexed by port
    logic    arready_bus [2];
    axi_r_t  r_bus [2];

    // Golden transactions
    string      op_q [$];
    addr_t      addr_q [$];
    data_t      wdata_q [$];
    strb_t      type_q [$];
    logic [3:0] exp_q [$];
    int         line_count = 0;

    // Slave delays with a third row for the write channel
    logic [1:0] delay_pool [3][64];
    int         pool_idx [3];

    // Monitor results
    axi_ar_t ar_seen [2];
    axi_ar_t ar_prev [2];
    logic    ar_stalled [2];
    time     ar_time [2];
    int      last_cnt [2];
    int      i_low;
    int      d_low;
    logic    m0_busy;
    int      errors;

    tb_clock_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(5)) clk_gen (
        .ACLK    (ACLK),
        .ARESETn (ARESETn)
    );

    cache_axi_bridge #(.REFILL_BEATS(4), .UNCACHED_PAGE(16'h1000)) dut0 (
        .ACLK         (ACLK),
        .ARESETn      (ARESETn),
        .i_req_i      (i_req),
        .i_addr_i     (i_addr),
        .i_wait_o     (i_wait),
        .d_req_i      (d_req),
        .d_write_i    (d_write),
        .d_addr_i     (d_addr),
        .d_wdata_i    (d_wdata),
        .d_type_i     (d_type),
        .d_wait_o     (d_wait),
        .m0_ar_o      (m0_ar),
        .m0_arready_i (arready_bus[0]),
        .m0_r_i       (r_bus[0]),
        .m0_rready_o  (m0_rready),
        .m1_ar_o      (m1_ar),
        .m1_arready_i (arready_bus[1]),
        .m1_r_i       (r_bus[1]),
        .m1_rready_o  (m1_rready),
        .m1_aw_o      (m1_aw),
        .m1_awready_i (m1_awready),
        .m1_w_o       (m1_w),
        .m1_wready_i  (m1_wready),
        .m1_b_i       (m1_b),
        .m1_bready_o  (m1_bready)
    );

    function automatic axi_ar_t ar_of(input int p);
        return (p == 0) ? m0_ar : m1_ar;
    endfunction

    function automatic logic rready_of(input int p);
        return (p == 0) ? m0_rready : m1_rready;
    endfunction

    function automatic int unsigned next_delay(input int p);
        int unsigned d;
        d = delay_pool[p][pool_idx[p]];
        pool_idx[p] = (pool_idx[p] + 1) % 64;
        return d;
    endfunction

    task automatic report_fail(input string msg);
        errors++;
        $display("FAIL at %0d ns: %s", $time, msg);
    endtask

    ////////////////////
    // AXI slave models
    ////////////////////
    // AR sampled on rising edges
    // Ready and beats driven on falling edges
    task automatic serve_read(input int p);
        axi_ar_t cur;
        @(posedge ACLK);
        cur = ar_of(p);
        if (ARESETn && cur.valid) begin
            repeat (next_delay(p)) @(negedge ACLK);
            @(negedge ACLK);
            arready_bus[p] = 1'b1;
            @(negedge ACLK);
            arready_bus[p] = 1'b0;
            for (int b = 0; b <= int'(cur.len); b++) begin
                repeat (next_delay(p)) @(negedge ACLK);
                r_bus[p].data  = cur.addr + 32'(4 * b);
                r_bus[p].last  = (b == int'(cur.len));
                r_bus[p].valid = 1'b1;
                // RREADY only moves on rising edges
                while (!rready_of(p)) @(negedge ACLK);
                @(negedge ACLK);
                r_bus[p].valid = 1'b0;
                r_bus[p].last  = 1'b0;
            end
        end
    endtask

    task automatic serve_write();
        @(posedge ACLK);
        if (ARESETn && m1_aw.valid) begin
            repeat (next_delay(2)) @(negedge ACLK);
            @(negedge ACLK);
            m1_awready = 1'b1;
            m1_wready  = 1'b1;
            @(negedge ACLK);
            m1_awready = 1'b0;
            m1_wready  = 1'b0;
        end
    endtask

    initial begin
        @(posedge ARESETn);
        forever serve_read(0);
    end

    initial begin
        @(posedge ARESETn);
        forever serve_read(1);
    end

    initial begin
        @(posedge ARESETn);
        forever serve_write();
    end

    ////////////////////
    // Bus monitor
    ////////////////////
    // Pre-edge values as the DUT sees them
    always @(posedge ACLK) begin
        axi_ar_t cur;
        if (ARESETn) begin
            for (int p = 0; p < 2; p++) begin
                cur = ar_of(p);
                if (ar_stalled[p] && cur !== ar_prev[p]) begin
                    report_fail($sformatf("M%0d AR changed while ARREADY low", p));
                end
                ar_stalled[p] = cur.valid && !arready_bus[p];
                ar_prev[p]    = cur;
                if (cur.valid && arready_bus[p]) begin
                    ar_seen[p] = cur;
                    ar_time[p] = $time;
                end
                if (r_bus[p].valid && rready_of(p) && r_bus[p].last) begin
                    last_cnt[p]++;
                end
            end
            // One read port receiving at a time
            if (m0_rready && m1_rready) begin
                report_fail("RREADY high on both ports");
            end
            // No data read while a refill is open
            if (m1_ar.valid && m0_busy) begin
                report_fail("M1 ARVALID high before M0 last beat");
            end
            if (m0_rready && r_bus[0].valid && r_bus[0].last) begin
                m0_busy = 1'b0;
            end else if (m0_ar.valid) begin
                m0_busy = 1'b1;
            end
            if (!i_wait) i_low++;
            if (!d_wait) d_low++;
        end
    end

    ////////////////////
    // Checks
    ////////////////////
    task automatic check_ar(input int p, input addr_t addr, input logic [3:0] len);
        if (ar_seen[p].addr !== addr) begin
            report_fail($sformatf("M%0d ARADDR %h, expected %h", p, ar_seen[p].addr, addr));
        end
        if (ar_seen[p].len !== len) begin
            report_fail($sformatf("M%0d ARLEN %0d, expected %0d", p, ar_seen[p].len, len));
        end
        // Word beats with INCR and ID zero
        if (ar_seen[p].size !== 3'd2 || ar_seen[p].burst !== 2'd1 || ar_seen[p].id !== 4'd0) begin
            report_fail($sformatf("M%0d ARSIZE/ARBURST/ARID %0d/%0d/%0d", p,
                ar_seen[p].size, ar_seen[p].burst, ar_seen[p].id));
        end
    endtask

    task automatic run_write(input addr_t addr, input data_t wdata, input strb_t typ,
                             input logic [3:0] strb);
        logic done;
        done    = 1'b0;
        d_addr  = addr;
        d_wdata = wdata;
        d_type  = typ;
        d_write = 1'b1;
        while (!done) begin
            @(posedge ACLK);
            if (m1_aw.valid !== 1'b1 || m1_w.valid !== 1'b1) begin
                report_fail("AWVALID or WVALID low during write");
            end
            if (m1_aw.addr !== addr) begin
                report_fail($sformatf("AWADDR %h, expected %h", m1_aw.addr, addr));
            end
            if (m1_w.data !== wdata) begin
                report_fail($sformatf("WDATA %h, expected %h", m1_w.data, wdata));
            end
            if (m1_w.strb !== strb) begin
                report_fail($sformatf("WSTRB %h, expected %h", m1_w.strb, strb));
            end
            if (m1_w.last !== 1'b1 || m1_bready !== 1'b1) begin
                report_fail("WLAST or BREADY not held high");
            end
            if (m1_wready) begin
                if (d_wait !== 1'b0) report_fail("d_wait high on W handshake");
                done = 1'b1;
            end else if (d_wait !== 1'b1) begin
                report_fail("d_wait low without WREADY");
            end
        end
        @(negedge ACLK);
        d_write = 1'b0;
    endtask

    task automatic run_line(input int k);
        int base0;
        int base1;
        base0 = last_cnt[0];
        base1 = last_cnt[1];
        i_low = 0;
        d_low = 0;
        case (op_q[k])
            "I": begin
                i_addr = addr_q[k];
                i_req  = 1'b1;
                while (last_cnt[0] == base0) @(negedge ACLK);
                i_req = 1'b0;
                check_ar(0, addr_q[k], exp_q[k]);
                if (i_low != int'(exp_q[k]) + 1) begin
                    report_fail($sformatf("i_wait low %0d cycles, expected %0d",
                        i_low, exp_q[k] + 1));
                end
            end
            "D", "DU": begin
                d_addr = addr_q[k];
                d_req  = 1'b1;
                while (last_cnt[1] == base1) @(negedge ACLK);
                d_req = 1'b0;
                check_ar(1, addr_q[k], exp_q[k]);
                if (d_low != int'(exp_q[k]) + 1) begin
                    report_fail($sformatf("d_wait low %0d cycles, expected %0d",
                        d_low, exp_q[k] + 1));
                end
            end
            "ID": begin
                // Data address rides in the wdata column
                i_addr = addr_q[k];
                d_addr = wdata_q[k];
                i_req  = 1'b1;
                d_req  = 1'b1;
                while (last_cnt[0] == base0) @(negedge ACLK);
                i_req = 1'b0;
                while (last_cnt[1] == base1) @(negedge ACLK);
                d_req = 1'b0;
                check_ar(0, addr_q[k], 4'd3);
                check_ar(1, wdata_q[k], exp_q[k]);
                if (ar_time[0] >= ar_time[1]) begin
                    report_fail("M1 AR accepted before M0 AR");
                end
                if (i_low != 4 || d_low != int'(exp_q[k]) + 1) begin
                    report_fail($sformatf("Wait low counts i %0d d %0d", i_low, d_low));
                end
            end
            "W": begin
                run_write(addr_q[k], wdata_q[k], type_q[k], exp_q[k]);
            end
            default: begin
                report_fail($sformatf("Unknown operation %s in golden line", op_q[k]));
            end
        endcase
        repeat (2) @(negedge ACLK);
    endtask

    task automatic read_golden();
        int         fd;
        int         rc;
        string      line;
        string      op;
        addr_t      a;
        data_t      w;
        strb_t      t;
        logic [3:0] e;
        fd = $fopen("testbench/bridge_golden.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the golden file testbench/bridge_golden.txt");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                rc = $fgets(line, fd);
                // Skip comments and blank lines
                if (rc > 1 && line[0] != "#") begin
                    if ($sscanf(line, "%s %h %h %h %h", op, a, w, t, e) == 5) begin
                        op_q.push_back(op);
                        addr_q.push_back(a);
                        wdata_q.push_back(w);
                        type_q.push_back(t);
                        exp_q.push_back(e);
                    end
                end
            end
            $fclose(fd);
            line_count = op_q.size();
        end
    endtask

    // Watchdog sized from the golden file
    initial begin
        wait (line_count > 0);
        #((line_count + 1) * CYCLES_PER_TX * CLK_PERIOD);
        $display("Timeout: bridge did not finish %0d transactions in time", line_count);
        $display("Test failed");
        $finish;
    end

    initial begin
        i_req      = 1'b0;
        i_addr     = '0;
        d_req      = 1'b0;
        d_write    = 1'b0;
        d_addr     = '0;
        d_wdata    = '0;
        d_type     = '0;
        m1_awready = 1'b0;
        m1_wready  = 1'b0;
        m1_b       = '0;
        errors     = 0;
        m0_busy    = 1'b0;
        i_low      = 0;
        d_low      = 0;
        for (int p = 0; p < 2; p++) begin
            arready_bus[p] = 1'b0;
            r_bus[p]       = '0;
            ar_stalled[p]  = 1'b0;
            ar_prev[p]     = '0;
            ar_seen[p]     = '0;
            ar_time[p]     = 0;
            last_cnt[p]    = 0;
        end
        void'($urandom(32'h8b60_dc29));
        for (int p = 0; p < 3; p++) begin
            pool_idx[p] = 0;
            for (int n = 0; n < 64; n++) delay_pool[p][n] = 2'($urandom % 4);
        end
        read_golden();
        if (line_count == 0) begin
            $display("Golden file holds no transactions");
            errors++;
        end
        @(posedge ARESETn);
        // Registered outputs settle before the falling edge
        if (m0_ar.valid !== 1'b0 || m1_ar.valid !== 1'b0) begin
            report_fail("ARVALID high after reset");
        end
        if (m0_rready !== 1'b0 || m1_rready !== 1'b0) begin
            report_fail("RREADY high after reset");
        end
        for (int k = 0; k < line_count; k++) begin
            run_line(k);
        end
        $display("Transactions: %0d, errors: %0d", line_count, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule : tb_cache_axi_bridge

// File: testbench/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD       = 20,
    parameter int RESET_CYCLES = 5
) (
    output logic ACLK,
    output logic ARESETn
);

    // Free running bus clock
    initial begin
        ACLK = 1'b0;
        forever #(PERIOD / 2) ACLK = ~ACLK;
    end

    // Reset held for a few edges, released on a falling edge
    initial begin
        ARESETn = 1'b0;
        repeat (RESET_CYCLES) @(posedge ACLK);
        @(negedge ACLK);
        ARESETn = 1'b1;
    end

endmodule : tb_clock_gen

// File: verilog/axi_read_channel.sv
`timescale 1ns/1ps

module axi_read_channel
    import bridge_pkg::*;
(
    input  logic    ACLK,
    input  logic    ARESETn,

    // From the arbiter
    input  logic    ar_load_i,
    input  axi_ar_t ar_req_i,
    input  logic    r_recv_i,

    // Bus side
    input  logic    arready_i,
    input  axi_r_t  r_i,
    output axi_ar_t ar_o,
    output logic    rready_o,

    // Handshake strobes back to the arbiter
    output logic    ar_done_o,
    output logic    r_beat_o,
    output logic    r_last_o
);

    ////////////////////
    // AR channel
    ////////////////////
    // Reloaded every cycle the arbiter sits in AR,
    // request stays stable since the cache holds its address
    always_ff @(posedge ACLK) begin
        if (!ARESETn) begin
            ar_o <= '0;
        end else if (ar_load_i) begin
            ar_o <= ar_req_i;
        end else begin
            // Idle bus, fields parked at zero
            ar_o <= '0;
        end
    end

    ////////////////////
    // R channel
    ////////////////////
    // Rises with the AR drop, falls after the last beat
    always_ff @(posedge ACLK) begin
        if (!ARESETn) begin
            rready_o <= 1'b0;
        end else begin
            rready_o <= r_recv_i;
        end
    end

    // Handshake detection
    assign ar_done_o = ar_o.valid & arready_i;
    assign r_beat_o  = r_i.valid & rready_o;
    // RID and RRESP not checked
    assign r_last_o  = r_beat_o & r_i.last;

endmodule : axi_read_channel

// File: verilog/axi_write_channel.sv
`timescale 1ns/1ps

module axi_write_channel
    import bridge_pkg::*;
(
    // Data cache request
    input  logic    d_req_i,
    input  logic    d_write_i,
    input  addr_t   d_addr_i,
    input  data_t   d_wdata_i,
    // Active-low byte mask
    input  strb_t   d_type_i,

    // Bus side, AWREADY and B not looked at
    input  logic    awready_i,
    input  logic    wready_i,
    input  axi_b_t  b_i,

    // Accepted M1 read beat
    input  logic    r_beat_i,

    output axi_aw_t aw_o,
    output axi_w_t  w_o,
    output logic    bready_o,
    output logic    d_wait_o
);

    logic w_done;

    ////////////////////
    // Write address and data
    ////////////////////
    // Single beat, forwarded straight from the cache
    always_comb begin
        aw_o.id    = '0;
        aw_o.addr  = d_addr_i;
        aw_o.len   = '0;
        aw_o.size  = AXI_SIZE_WORD;
        aw_o.burst = AXI_BURST_INCR;
        aw_o.valid = d_write_i;
    end

    always_comb begin
        w_o.data  = d_wdata_i;
        // Strobe is the mask turned active high
        w_o.strb  = ~d_type_i;
        w_o.last  = 1'b1;
        w_o.valid = d_write_i;
    end

    // Response always accepted
    assign bready_o = 1'b1;

    // Data accepted on W, AW assumed taken along with it
    assign w_done = w_o.valid & wready_i;

    // Wait merge, read beats first then the write
    always_comb begin
        if (d_req_i) begin
            d_wait_o = ~r_beat_i;
        end else if (d_write_i) begin
            d_wait_o = ~w_done;
        end else begin
            d_wait_o = 1'b1;
        end
    end

endmodule : axi_write_channel

// File: verilog/bridge_pkg.sv
package bridge_pkg;

    ////////////////////
    // Bus widths
    ////////////////////
    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    // Byte strobe, also the cache byte-type mask
    typedef logic [3:0]  strb_t;
    typedef logic [3:0]  axi_id_t;
    // Burst length minus one
    typedef logic [3:0]  axi_len_t;
    typedef logic [2:0]  axi_size_t;
    typedef logic [1:0]  axi_burst_t;
    typedef logic [1:0]  axi_resp_t;

    // Four bytes per beat
    localparam axi_size_t  AXI_SIZE_WORD  = 3'd2;
    localparam axi_burst_t AXI_BURST_INCR = 2'd1;

    ////////////////////
    // Channel structs
    ////////////////////
    // Read address, also reused for write address
    typedef struct packed {
        axi_id_t    id;
        addr_t      addr;
        axi_len_t   len;
        axi_size_t  size;
        axi_burst_t burst;
        logic       valid;
    } axi_ar_t;

    typedef axi_ar_t axi_aw_t;

    typedef struct packed {
        axi_id_t   id;
        data_t     data;
        axi_resp_t resp;
        logic      last;
        logic      valid;
    } axi_r_t;

    typedef struct packed {
        data_t data;
        strb_t strb;
        logic  last;
        logic  valid;
    } axi_w_t;

    typedef struct packed {
        axi_id_t   id;
        axi_resp_t resp;
        logic      valid;
    } axi_b_t;

    // Shared read FSM states
    typedef enum logic [2:0] {
        REFILL_IDLE,
        REFILL_M0_AR,
        REFILL_M0_R,
        REFILL_M1_AR,
        REFILL_M1_R
    } refill_state_e;

endpackage : bridge_pkg

// File: verilog/cache_axi_bridge.sv
`timescale 1ns/1ps

module cache_axi_bridge
    import bridge_pkg::*;
#(
    parameter int          REFILL_BEATS  = 4,
    parameter logic [15:0] UNCACHED_PAGE = 16'h1000
) (
    input  logic    ACLK,
    input  logic    ARESETn,

    // Instruction cache side
    input  logic    i_req_i,
    input  addr_t   i_addr_i,
    output logic    i_wait_o,

    // Data cache side
    input  logic    d_req_i,
    input  logic    d_write_i,
    input  addr_t   d_addr_i,
    input  data_t   d_wdata_i,
    input  strb_t   d_type_i,
    output logic    d_wait_o,

    // M0, read only
    output axi_ar_t m0_ar_o,
    input  logic    m0_arready_i,
    input  axi_r_t  m0_r_i,
    output logic    m0_rready_o,

    // M1, read and write
    output axi_ar_t m1_ar_o,
    input  logic    m1_arready_i,
    input  axi_r_t  m1_r_i,
    output logic    m1_rready_o,
    output axi_aw_t m1_aw_o,
    input  logic    m1_awready_i,
    output axi_w_t  m1_w_o,
    input  logic    m1_wready_i,
    input  axi_b_t  m1_b_i,
    output logic    m1_bready_o
);

    // Arbiter to read channels
    logic    m0_ar_load;
    logic    m0_r_recv;
    axi_ar_t m0_ar_req;
    logic    m1_ar_load;
    logic    m1_r_recv;
    axi_ar_t m1_ar_req;

    // Handshake strobes back to the arbiter
    logic    m0_ar_done;
    logic    m0_r_beat;
    logic    m0_r_last;
    logic    m1_ar_done;
    logic    m1_r_beat;
    logic    m1_r_last;

    ////////////////////
    // Read FSM
    ////////////////////
    refill_arbiter #(
        .REFILL_BEATS  (REFILL_BEATS),
        .UNCACHED_PAGE (UNCACHED_PAGE)
    ) arb (
        .ACLK          (ACLK),
        .ARESETn       (ARESETn),
        .i_req_i       (i_req_i),
        .i_addr_i      (i_addr_i),
        .d_req_i       (d_req_i),
        .d_addr_i      (d_addr_i),
        .m0_ar_done_i  (m0_ar_done),
        .m0_r_beat_i   (m0_r_beat),
        .m0_r_last_i   (m0_r_last),
        .m1_ar_done_i  (m1_ar_done),
        .m1_r_last_i   (m1_r_last),
        .m0_ar_load_o  (m0_ar_load),
        .m0_r_recv_o   (m0_r_recv),
        .m0_ar_req_o   (m0_ar_req),
        .m1_ar_load_o  (m1_ar_load),
        .m1_r_recv_o   (m1_r_recv),
        .m1_ar_req_o   (m1_ar_req),
        .i_wait_o      (i_wait_o)
    );

    ////////////////////
    // Port read channels
    ////////////////////
    // Instruction refills
    axi_read_channel rd_m0 (
        .ACLK       (ACLK),
        .ARESETn    (ARESETn),
        .ar_load_i  (m0_ar_load),
        .ar_req_i   (m0_ar_req),
        .arready_i  (m0_arready_i),
        .r_recv_i   (m0_r_recv),
        .r_i        (m0_r_i),
        .ar_o       (m0_ar_o),
        .rready_o   (m0_rready_o),
        .ar_done_o  (m0_ar_done),
        .r_beat_o   (m0_r_beat),
        .r_last_o   (m0_r_last)
    );

    // Data reads
    axi_read_channel rd_m1 (
        .ACLK       (ACLK),
        .ARESETn    (ARESETn),
        .ar_load_i  (m1_ar_load),
        .ar_req_i   (m1_ar_req),
        .arready_i  (m1_arready_i),
        .r_recv_i   (m1_r_recv),
        .r_i        (m1_r_i),
        .ar_o       (m1_ar_o),
        .rready_o   (m1_rready_o),
        .ar_done_o  (m1_ar_done),
        .r_beat_o   (m1_r_beat),
        .r_last_o   (m1_r_last)
    );

    // Single-beat data writes, plus data wait merge
    axi_write_channel wr_m1 (
        .d_req_i    (d_req_i),
        .d_write_i  (d_write_i),
        .d_addr_i   (d_addr_i),
        .d_wdata_i  (d_wdata_i),
        .d_type_i   (d_type_i),
        .awready_i  (m1_awready_i),
        .wready_i   (m1_wready_i),
        .b_i        (m1_b_i),
        .r_beat_i   (m1_r_beat),
        .aw_o       (m1_aw_o),
        .w_o        (m1_w_o),
        .bready_o   (m1_bready_o),
        .d_wait_o   (d_wait_o)
    );

endmodule : cache_axi_bridge

// File: verilog/refill_arbiter.sv
`timescale 1ns/1ps

module refill_arbiter
    import bridge_pkg::*;
#(
    parameter int          REFILL_BEATS  = 4,
    parameter logic [15:0] UNCACHED_PAGE = 16'h1000
) (
    input  logic    ACLK,
    input  logic    ARESETn,

    input  logic    i_req_i,
    input  addr_t   i_addr_i,
    input  logic    d_req_i,
    input  addr_t   d_addr_i,

    // Handshakes seen by the read channels
    input  logic    m0_ar_done_i,
    input  logic    m0_r_beat_i,
    input  logic    m0_r_last_i,
    input  logic    m1_ar_done_i,
    input  logic    m1_r_last_i,

    output logic    m0_ar_load_o,
    output logic    m0_r_recv_o,
    output axi_ar_t m0_ar_req_o,
    output logic    m1_ar_load_o,
    output logic    m1_r_recv_o,
    output axi_ar_t m1_ar_req_o,
    output logic    i_wait_o
);

    // Cacheable burst length, as AXI len
    localparam axi_len_t BURST_LEN = axi_len_t'(REFILL_BEATS - 1);

    refill_state_e state_q;
    refill_state_e state_d;

    // Data address inside the uncached page
    logic          d_uncached;

    ////////////////////
    // State register
    ////////////////////
    always_ff @(posedge ACLK) begin
        if (!ARESETn) begin
            state_q <= REFILL_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Next state, instruction wins from idle
    always_comb begin
        state_d = state_q;
        case (state_q)
            REFILL_IDLE: begin
                if (i_req_i) begin
                    state_d = REFILL_M0_AR;
                end else if (d_req_i) begin
                    state_d = REFILL_M1_AR;
                end
            end
            REFILL_M0_AR: begin
                if (m0_ar_done_i) begin
                    state_d = REFILL_M0_R;
                end
            end
            REFILL_M0_R: begin
                // Hand over to a waiting data read
                if (m0_r_last_i) begin
                    state_d = d_req_i ? REFILL_M1_AR : REFILL_IDLE;
                end
            end
            REFILL_M1_AR: begin
                if (m1_ar_done_i) begin
                    state_d = REFILL_M1_R;
                end
            end
            REFILL_M1_R: begin
                // And back to a waiting refill
                if (m1_r_last_i) begin
                    state_d = i_req_i ? REFILL_M0_AR : REFILL_IDLE;
                end
            end
            default: begin
                state_d = REFILL_IDLE;
            end
        endcase
    end

    ////////////////////
    // Channel controls
    ////////////////////
    // Decoded from next state so the channels register in step
    assign m0_ar_load_o = (state_d == REFILL_M0_AR);
    assign m0_r_recv_o  = (state_d == REFILL_M0_R);
    assign m1_ar_load_o = (state_d == REFILL_M1_AR);
    assign m1_r_recv_o  = (state_d == REFILL_M1_R);

    assign d_uncached = (d_addr_i[31:16] == UNCACHED_PAGE);

    // Instruction refill, always a full INCR burst
    always_comb begin
        m0_ar_req_o.id    = '0;
        m0_ar_req_o.addr  = i_addr_i;
        m0_ar_req_o.len   = BURST_LEN;
        m0_ar_req_o.size  = AXI_SIZE_WORD;
        m0_ar_req_o.burst = AXI_BURST_INCR;
        m0_ar_req_o.valid = m0_ar_load_o;
    end

    // Data read, single beat when uncached
    always_comb begin
        m1_ar_req_o.id    = '0;
        m1_ar_req_o.addr  = d_addr_i;
        m1_ar_req_o.len   = d_uncached ? axi_len_t'(0) : BURST_LEN;
        m1_ar_req_o.size  = AXI_SIZE_WORD;
        m1_ar_req_o.burst = AXI_BURST_INCR;
        m1_ar_req_o.valid = m1_ar_load_o;
    end

    // Icache samples RDATA on each accepted M0 beat
    assign i_wait_o = ~m0_r_beat_i;

endmodule : refill_arbiter
